// File: sources.f
src/deskew_pkg.sv
src/skew_counter.sv
src/deskew_fsm.sv
src/lane_delay_fifo.sv
src/deskew_top.sv
verification/deskew_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module deskew_tb \
    -f sources.f \
    -o deskew_sim

sim_output=$(./obj_dir/deskew_sim 2>&1) || true
echo "$sim_output"

if grep -qx "all tests passed" <<< "$sim_output"
then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1

// File: verification/deskew_tb.sv
module deskew_tb
    import deskew_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int LEAD_BEATS   = 4;
    localparam int ALIGN_BEATS  = 24;
    localparam int N_ROWS       = 7;

    logic                 i_clock;
    logic                 i_arst_n;
    logic                 i_rf_enable;
    logic                 i_valid;
    lane_mask_t           i_resync;
    lane_mask_t           i_start_of_lane;
    block_t [N_LANES-1:0] i_data;
    logic                 o_set_fifo_delay;
    logic                 o_skew_error;
    delay_t [N_LANES-1:0] o_lane_delay;
    logic                 o_valid;
    block_t [N_LANES-1:0] o_data;

    // Lane offsets in beats with lane 0 first
    int unsigned row_offsets [N_ROWS][N_LANES] = '{
        '{0, 3, 1, 7},
        '{0, 2, 5, 20},
        '{4, 4, 4, 4},
        '{0, 3, 1, 7},
        '{2, 9, 0, 16},
        '{1, 0, 3, 2},
        '{5, 0, 0, 3}
    };
    // Expected error pulse, random valid gaps, block enabled
    bit row_error  [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    bit row_gaps   [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    bit row_enable [N_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    int unsigned errors;
    int unsigned checks;
    int unsigned set_count;
    int unsigned error_count;
    int          row_idx;
    logic [31:0] beat;
    logic [31:0] marker_beat;
    logic [31:0] row_max;
    logic [31:0] prev_beat;
    logic        prev_valid;
    logic        resync_req;
    logic        align_on;
    logic [31:0] lfsr_state;

    deskew_top deskew_top_i (
        .i_clock          (i_clock),
        .i_arst_n         (i_arst_n),
        .i_rf_enable      (i_rf_enable),
        .i_valid          (i_valid),
        .i_resync         (i_resync),
        .i_start_of_lane  (i_start_of_lane),
        .i_data           (i_data),
        .o_set_fifo_delay (o_set_fifo_delay),
        .o_skew_error     (o_skew_error),
        .o_lane_delay     (o_lane_delay),
        .o_valid          (o_valid),
        .o_data           (o_data)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) i_clock = ~i_clock;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        return value[0] ? ((value >> 1) ^ 32'h8020_0003) : (value >> 1);
    endfunction

    task automatic take_random_bit(output logic bit_out);
        lfsr_state = lfsr_step(lfsr_state);
        bit_out = lfsr_state[0];
    endtask

    function automatic logic [31:0] max_offset(input int row);
        logic [31:0] result;
        result = 0;
        for (int i = 0; i < N_LANES; i++)
        begin
            if (row_offsets[row][i] > result)
            begin
                result = row_offsets[row][i];
            end
        end
        return result;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // Sample what the last edge produced, then drive the next beat
    task automatic step_cycle();
        logic b0;
        logic b1;
        logic valid;
        @(posedge i_clock);
        #DRIVE_DELAY;
        check_equal(32'(o_valid), 32'(prev_valid), "o_valid one clock after i_valid");
        if (o_set_fifo_delay)
        begin
            set_count++;
        end
        if (o_skew_error)
        begin
            error_count++;
        end
        if (align_on && prev_valid)
        begin
            for (int i = 0; i < N_LANES; i++)
            begin
                check_equal(o_data[i][31:0], prev_beat - row_max,
                            $sformatf("lane %0d aligned beat", i));
            end
        end
        valid = 1'b1;
        if (row_gaps[row_idx])
        begin
            take_random_bit(b0);
            take_random_bit(b1);
            valid = !(b0 && b1);
        end
        i_rf_enable     = row_enable[row_idx];
        i_valid         = valid;
        // Rotate the requesting lane to exercise the OR
        i_resync        = lane_mask_t'(resync_req) << (row_idx % N_LANES);
        resync_req      = 1'b0;
        i_start_of_lane = '0;
        if (valid)
        begin
            for (int i = 0; i < N_LANES; i++)
            begin
                i_data[i]          = block_t'(beat - row_offsets[row_idx][i]);
                i_start_of_lane[i] = ((beat - row_offsets[row_idx][i]) == marker_beat);
            end
            prev_beat = beat;
            beat++;
        end
        prev_valid = valid;
    endtask

    task automatic run_row(input int r);
        logic [31:0]          target;
        delay_t [N_LANES-1:0] saved_delay;
        row_idx     = r;
        row_max     = max_offset(r);
        marker_beat = beat + LEAD_BEATS;
        resync_req  = 1'b1;
        set_count   = 0;
        error_count = 0;
        saved_delay = o_lane_delay;
        if (!row_enable[r])
        begin
            target = marker_beat + row_max + 8;
            while (beat < target)
            begin
                step_cycle();
            end
            check_equal(set_count, 0, "set pulse while disabled");
            check_equal(error_count, 0, "error pulse while disabled");
        end
        else if (row_error[r])
        begin
            while (error_count == 0)
            begin
                step_cycle();
            end
            check_equal(set_count, 0, "set pulse on excess skew");
        end
        else
        begin
            while (set_count == 0)
            begin
                step_cycle();
            end
            check_equal(error_count, 0, "error pulse on legal skew");
            for (int i = 0; i < N_LANES; i++)
            begin
                check_equal(32'(o_lane_delay[i]), row_max - row_offsets[r][i],
                            $sformatf("lane %0d delay", i));
            end
            // Old read points flush out of the buffers
            target = beat + FIFO_DEPTH;
            while (beat < target)
            begin
                step_cycle();
            end
            align_on = 1'b1;
            target   = beat + ALIGN_BEATS;
            while (beat < target)
            begin
                step_cycle();
            end
            align_on = 1'b0;
        end
        // Rows that never lock leave the earlier delays in place
        if (!row_enable[r] || row_error[r])
        begin
            for (int i = 0; i < N_LANES; i++)
            begin
                check_equal(32'(o_lane_delay[i]), 32'(saved_delay[i]),
                            $sformatf("lane %0d delay kept", i));
            end
        end
    endtask

    initial
    begin
        i_arst_n        = 1'b0;
        i_rf_enable     = 1'b0;
        i_valid         = 1'b0;
        i_resync        = '0;
        i_start_of_lane = '0;
        i_data          = '0;
        errors          = 0;
        checks          = 0;
        set_count       = 0;
        error_count     = 0;
        row_idx         = 0;
        beat            = 32'd64;
        marker_beat     = '0;
        row_max         = '0;
        prev_beat       = '0;
        prev_valid      = 1'b0;
        resync_req      = 1'b0;
        align_on        = 1'b0;
        lfsr_state      = 32'hdc8;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_arst_n = 1'b1;
        for (int r = 0; r < N_ROWS; r++)
        begin
            run_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // Bound on the whole run at four clocks per expected beat
    initial
    begin : watchdog
        int unsigned total_beats;
        total_beats = RESET_CYCLES;
        for (int r = 0; r < N_ROWS; r++)
        begin
            total_beats += LEAD_BEATS + max_offset(r) + FIFO_DEPTH + ALIGN_BEATS + 8;
        end
        #(total_beats * CLK_PERIOD * 4);
        $display("Watchdog expired, no set or error pulse arrived in time");
        $display("tests failed");
        $finish;
    end

endmodule

// File: src/deskew_top.sv
module deskew_top
    import deskew_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_rf_enable,
    input  logic                 i_valid,
    input  lane_mask_t           i_resync,
    input  lane_mask_t           i_start_of_lane,
    input  block_t [N_LANES-1:0] i_data,
    output logic                 o_set_fifo_delay,
    output logic                 o_skew_error,
    output delay_t [N_LANES-1:0] o_lane_delay,
    output logic                 o_valid,
    output block_t [N_LANES-1:0] o_data
);

    logic                 resync_any;
    logic                 enable_counters;
    logic                 clear_counters;
    logic                 stop_common;
    lane_mask_t           stop_lanes;
    delay_t               common_count;
    delay_t [N_LANES-1:0] lane_counts;

    // Any lane may ask for a new measurement
    assign resync_any = |i_resync;

    deskew_fsm u_deskew_fsm (
        .i_clock           (i_clock),
        .i_arst_n          (i_arst_n),
        .i_rf_enable       (i_rf_enable),
        .i_valid           (i_valid),
        .i_resync          (resync_any),
        .i_start_of_lane   (i_start_of_lane),
        .i_common_count    (common_count),
        .i_lane_counts     (lane_counts),
        .o_enable_counters (enable_counters),
        .o_clear_counters  (clear_counters),
        .o_stop_common     (stop_common),
        .o_stop_lanes      (stop_lanes),
        .o_set_fifo_delay  (o_set_fifo_delay),
        .o_skew_error      (o_skew_error),
        .o_lane_delay      (o_lane_delay)
    );

    // Ends on the largest offset
    skew_counter u_common_counter (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_clear  (clear_counters),
        .i_valid  (i_valid),
        .i_enable (enable_counters),
        .i_stop   (stop_common),
        .o_count  (common_count)
    );

    for (genvar i = 0; i < N_LANES; i++)
    begin : g_lane
        // Latches this lane's marker offset
        skew_counter u_lane_counter (
            .i_clock  (i_clock),
            .i_arst_n (i_arst_n),
            .i_clear  (clear_counters),
            .i_valid  (i_valid),
            .i_enable (enable_counters),
            .i_stop   (stop_lanes[i]),
            .o_count  (lane_counts[i])
        );

        lane_delay_fifo u_lane_delay_fifo (
            .i_clock          (i_clock),
            .i_arst_n         (i_arst_n),
            .i_valid          (i_valid),
            .i_set_fifo_delay (o_set_fifo_delay),
            .i_delay          (o_lane_delay[i]),
            .i_data           (i_data[i]),
            .o_data           (o_data[i])
        );
    end

    // Matches the register stage in the lane buffers
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

endmodule

// File: src/lane_delay_fifo.sv
module lane_delay_fifo
    import deskew_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_arst_n,
    input  logic   i_valid,
    input  logic   i_set_fifo_delay,
    input  delay_t i_delay,
    input  block_t i_data,
    output block_t o_data
);

    block_t mem [FIFO_DEPTH];
    delay_t wr_ptr;
    delay_t delay_q;
    delay_t rd_addr;

    // Read point trails the write point, wrapped into the buffer
    always_comb
    begin
        if (wr_ptr >= delay_q)
        begin
            rd_addr = wr_ptr - delay_q;
        end
        else
        begin
            rd_addr = wr_ptr + (delay_t'(FIFO_DEPTH) - delay_q);
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr  <= '0;
            delay_q <= '0;
        end
        else
        begin
            if (i_set_fifo_delay)
            begin
                delay_q <= i_delay;
            end
            if (i_valid)
            begin
                wr_ptr <= (wr_ptr == delay_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

    // Storage and output stage
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            mem[wr_ptr] <= i_data;
            // Zero delay has not reached the memory yet, take the input
            if (delay_q == '0)
            begin
                o_data <= i_data;
            end
            else
            begin
                o_data <= mem[rd_addr];
            end
        end
    end

    // The FSM never programs more delay than the skew limit
    a_delay_in_range: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_set_fifo_delay |=> (delay_q <= delay_t'(MAX_SKEW))
    );

endmodule

// File: src/deskew_fsm.sv
module deskew_fsm
    import deskew_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_rf_enable,
    input  logic                 i_valid,
    input  logic                 i_resync,
    input  lane_mask_t           i_start_of_lane,
    input  delay_t               i_common_count,
    input  delay_t [N_LANES-1:0] i_lane_counts,
    output logic                 o_enable_counters,
    output logic                 o_clear_counters,
    output logic                 o_stop_common,
    output lane_mask_t           o_stop_lanes,
    output logic                 o_set_fifo_delay,
    output logic                 o_skew_error,
    output delay_t [N_LANES-1:0] o_lane_delay
);

    deskew_state_t state;
    deskew_state_t state_next;
    lane_mask_t    reported;
    lane_mask_t    reported_next;
    lane_mask_t    marker_hits;
    logic          skew_ok;
    logic          check_done;

    // Markers only count on valid beats
    assign marker_hits = i_valid ? i_start_of_lane : '0;

    // Every lane in and within the limit
    assign skew_ok    = (&reported) && (i_common_count <= delay_t'(MAX_SKEW));
    assign check_done = (state == ST_CHECK) && i_rf_enable && !i_resync;

    // Counter control
    assign o_enable_counters = (state == ST_COUNT);
    assign o_clear_counters  = (state == ST_IDLE) || (state == ST_WAIT_FIRST);
    assign o_stop_lanes      = reported;
    // Common count freezes at the largest offset once all lanes are in
    assign o_stop_common     = &reported;

    always_comb
    begin
        state_next    = state;
        reported_next = reported;
        case (state)
            ST_IDLE:
            begin
                if (i_rf_enable)
                begin
                    state_next = ST_WAIT_FIRST;
                end
            end
            ST_WAIT_FIRST:
            begin
                reported_next = marker_hits;
                if (|marker_hits)
                begin
                    // All lanes may already be aligned on the first beat
                    state_next = (&marker_hits) ? ST_CHECK : ST_COUNT;
                end
            end
            ST_COUNT:
            begin
                // Repeated markers on a reported lane change nothing
                reported_next = reported | marker_hits;
                // Give up early once the spread is already too wide
                if ((&reported_next) || (i_common_count > delay_t'(MAX_SKEW)))
                begin
                    state_next = ST_CHECK;
                end
            end
            ST_CHECK:
            begin
                state_next = skew_ok ? ST_LOCKED : ST_WAIT_FIRST;
            end
            default:
            begin
                state_next = state;
            end
        endcase

        if (!i_rf_enable)
        begin
            state_next = ST_IDLE;
        end
        else if (i_resync)
        begin
            state_next = ST_WAIT_FIRST;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state    <= ST_IDLE;
            reported <= '0;
        end
        else
        begin
            state <= state_next;
            // Fresh mask for every new measurement
            if ((state_next == ST_IDLE) || (state_next == ST_WAIT_FIRST))
            begin
                reported <= '0;
            end
            else
            begin
                reported <= reported_next;
            end
        end
    end

    // Result strobes and the delays they announce
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_set_fifo_delay <= 1'b0;
            o_skew_error     <= 1'b0;
            o_lane_delay     <= '0;
        end
        else
        begin
            o_set_fifo_delay <= check_done && skew_ok;
            o_skew_error     <= check_done && !skew_ok;
            if (check_done && skew_ok)
            begin
                for (int i = 0; i < N_LANES; i++)
                begin
                    // Early lanes wait for the latest one
                    o_lane_delay[i] <= i_common_count - i_lane_counts[i];
                end
            end
        end
    end

    a_set_xor_error: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        !(o_set_fifo_delay && o_skew_error)
    );

    a_single_cycle_result: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        (o_set_fifo_delay || o_skew_error) |=> !(o_set_fifo_delay || o_skew_error)
    );

endmodule

// File: src/skew_counter.sv
module skew_counter
    import deskew_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_arst_n,
    input  logic   i_clear,
    input  logic   i_valid,
    input  logic   i_enable,
    input  logic   i_stop,
    output delay_t o_count
);

    logic count_step;

    // Only valid beats of an active measurement advance the count
    assign count_step = i_valid && i_enable && !i_stop;

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_count <= '0;
        end
        else if (i_clear)
        begin
            o_count <= '0;
        end
        else if (count_step)
        begin
            // Saturate so a lost marker cannot wrap back to a small offset
            if (o_count != '1)
            begin
                o_count <= o_count + 1'b1;
            end
        end
    end

    // A stopped counter holds the offset it latched
    a_hold_when_stopped: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_stop |=> (o_count == $past(o_count))
    );

endmodule

// File: src/deskew_pkg.sv
package deskew_pkg;

    // Link geometry
    localparam int N_LANES        = 4;
    localparam int NB_DATA_CODED  = 66;

    // Per-lane delay buffer depth
    localparam int FIFO_DEPTH     = 20;

    // Largest lane-to-lane skew that can be absorbed, in valid beats
    localparam int MAX_SKEW       = 16;

    // Offsets and delays index into the lane buffer
    localparam int NB_DELAY_COUNT = $clog2(FIFO_DEPTH);

    // One 64b/66b coded block on a single lane
    typedef logic [NB_DATA_CODED-1:0] block_t;

    // Marker offset or programmed delay
    typedef logic [NB_DELAY_COUNT-1:0] delay_t;

    // One flag per lane
    typedef logic [N_LANES-1:0] lane_mask_t;

    // Skew measurement FSM
    typedef enum logic [2:0]
    {
        // Block disabled
        ST_IDLE,
        // Armed, waiting for the earliest marker
        ST_WAIT_FIRST,
        // Counting until every lane has reported
        ST_COUNT,
        // Compare skew with the limit
        ST_CHECK,
        // Delays applied, hold until resync
        ST_LOCKED
    } deskew_state_t;

endpackage
